/* logic/cpuCfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Halfword address width of the whole memory
// Half of the halfwords sit in each bank
`define CPU_MEM_HALFADDR_BITS 10

// Program counter width, counted in halfwords
`define CPU_INSTR_HALFADDR_BITS 10

// Size of the register file
// Register 0 reads as zero
`define CPU_REG_COUNT 16

`endif

/* logic/cpuPkg.sv */
`include "cpuCfg.svh"

package cpuPkg;

   // Opcode field, bits 14 to 11 of the first halfword
   // Bit 15 set marks a long instruction with imm16 in the second halfword
   typedef enum logic [3:0] {
      OP_ADD  = 4'h0,
      OP_SUB  = 4'h1,
      OP_AND  = 4'h2,
      OP_OR   = 4'h3,
      OP_MOVI = 4'h4,
      OP_HALT = 4'h5,
      OP_LI   = 4'h8,
      OP_ADDI = 4'h9,
      OP_LD   = 4'hA,
      OP_ST   = 4'hB,
      OP_BEQ  = 4'hC,
      OP_JMP  = 4'hD
   } opcode_t;

   // Fetch to compute
   // First halfword in bits 15 to 0
   typedef struct packed {
      logic                                valid;
      logic                                isLong;
      logic [`CPU_INSTR_HALFADDR_BITS-1:0] pc;
      logic [31:0]                         instruction;
   } fetchOut_t;

   // Redirect from compute back to fetch
   typedef struct packed {
      logic                                request;
      logic                                relMode;
      logic [`CPU_INSTR_HALFADDR_BITS-1:0] target;
   } branchReq_t;

   // 32-bit data access, addr is a word index
   typedef struct packed {
      logic                               en;
      logic                               wen;
      logic [`CPU_MEM_HALFADDR_BITS-2:0]  addr;
      logic [31:0]                        wdata;
   } memReq_t;

   // One 16-bit bank port
   typedef struct packed {
      logic                               en;
      logic                               wen;
      logic [`CPU_MEM_HALFADDR_BITS-2:0]  addr;
      logic [15:0]                        wdata;
   } bankPort_t;

endpackage

/* logic/halfMemory.sv */
`timescale 1ns/1ps
`include "cpuCfg.svh"

// One 16-bit memory bank
module halfMemory (
   input  logic              CLK,
   input  cpuPkg::bankPort_t port,
   output logic [15:0]       rdata
);

   localparam int Depth = 1 << (`CPU_MEM_HALFADDR_BITS - 1);

   logic [15:0] mem [Depth];

   // Registered read, old data on a same-cycle write
   // Output holds while the bank is idle
   always_ff @(posedge CLK) begin
      if (port.en) begin
         if (port.wen) begin
            mem[port.addr] <= port.wdata;
         end
         rdata <= mem[port.addr];
      end
   end

endmodule

/* logic/memArbiter.sv */
`timescale 1ns/1ps
`include "cpuCfg.svh"

// Bank steering between loader, data access and fetch
module memArbiter (
   input  logic                              CLK,
   input  logic                              arstN,
   input  logic                              run,
   input  logic                              loadWen,
   input  logic [`CPU_MEM_HALFADDR_BITS-1:0] loadAddr,
   input  logic [15:0]                       loadWdata,
   output logic [15:0]                       loadRdata,
   input  logic [`CPU_MEM_HALFADDR_BITS-2:0] fetchLowAddr,
   input  logic [`CPU_MEM_HALFADDR_BITS-2:0] fetchHighAddr,
   input  logic                              fetchStall,
   input  cpuPkg::memReq_t                   memReq,
   output logic [31:0]                       memRdata,
   output logic [15:0]                       fetchLowData,
   output logic [15:0]                       fetchHighData,
   output cpuPkg::bankPort_t                 lowPort,
   output cpuPkg::bankPort_t                 highPort,
   input  logic [15:0]                       lowRdata,
   input  logic [15:0]                       highRdata
);

   localparam int MemBits = `CPU_MEM_HALFADDR_BITS;

   // Bank picked by the last loader address
   logic loadSelHigh;

   always_comb begin
      lowPort = '0;
      highPort = '0;
      if (!run) begin
         // Loader owns memory, bit 0 picks the bank
         lowPort.en = !loadAddr[0];
         lowPort.wen = loadWen && !loadAddr[0];
         lowPort.addr = loadAddr[MemBits-1:1];
         lowPort.wdata = loadWdata;
         highPort.en = loadAddr[0];
         highPort.wen = loadWen && loadAddr[0];
         highPort.addr = loadAddr[MemBits-1:1];
         highPort.wdata = loadWdata;
      end else if (fetchStall) begin
         // Both banks form one data word
         lowPort.en = memReq.en;
         lowPort.wen = memReq.wen;
         lowPort.addr = memReq.addr;
         lowPort.wdata = memReq.wdata[15:0];
         highPort.en = memReq.en;
         highPort.wen = memReq.wen;
         highPort.addr = memReq.addr;
         highPort.wdata = memReq.wdata[31:16];
      end else begin
         // Instruction fetch, read only
         lowPort.en = 1'b1;
         lowPort.addr = fetchLowAddr;
         highPort.en = 1'b1;
         highPort.addr = fetchHighAddr;
      end
   end

   always_ff @(posedge CLK or negedge arstN) begin
      if (!arstN) begin
         loadSelHigh <= 1'b0;
      end else begin
         loadSelHigh <= loadAddr[0];
      end
   end

   // Read data lines up with the bank select from one cycle back
   assign loadRdata = loadSelHigh ? highRdata : lowRdata;
   assign memRdata = {highRdata, lowRdata};
   assign fetchLowData = lowRdata;
   assign fetchHighData = highRdata;

endmodule

/* logic/fetchStage.sv */
`timescale 1ns/1ps
`include "cpuCfg.svh"

// Fetch over two interleaved halfword banks
module fetchStage (
   input  logic                                CLK,
   input  logic                                arstN,
   input  logic                                run,
   input  logic                                stall,
   input  cpuPkg::branchReq_t                  branch,
   output logic [`CPU_MEM_HALFADDR_BITS-2:0]   lowAddr,
   output logic [`CPU_MEM_HALFADDR_BITS-2:0]   highAddr,
   input  logic [15:0]                         lowData,
   input  logic [15:0]                         highData,
   output cpuPkg::fetchOut_t                   fetchOut,
   output logic [`CPU_INSTR_HALFADDR_BITS-1:0] pc
);

   localparam int PcBits = `CPU_INSTR_HALFADDR_BITS;
   localparam int MemBits = `CPU_MEM_HALFADDR_BITS;

   // PC of the word now on the bank outputs
   logic [PcBits-1:0] pcQ;
   // That word came from a real fetch on the current path
   logic validQ;

   logic [15:0] firstHalf;
   logic [15:0] secondHalf;
   logic isLong;
   logic [PcBits-1:0] seqPc;
   logic [PcBits-1:0] fetchPc;
   logic [PcBits-1:0] redirectPc;
   logic [MemBits-1:0] memPc;
   logic [MemBits-1:0] memPcNext;

   // Odd PC puts the first halfword in the high bank
   assign firstHalf = pcQ[0] ? highData : lowData;
   assign secondHalf = pcQ[0] ? lowData : highData;

   // Length from bit 15 of the first halfword
   assign isLong = firstHalf[15];
   assign seqPc = pcQ + (isLong ? PcBits'(2) : PcBits'(1));

   // No valid word back means retry the held PC
   assign fetchPc = validQ ? seqPc : pcQ;

   // High bank at PC/2, low bank at (PC+1)/2
   // Yields halfwords PC and PC+1 in the same cycle
   assign memPc = MemBits'(fetchPc);
   assign memPcNext = memPc + 1'b1;
   assign highAddr = memPc[MemBits-1:1];
   assign lowAddr = memPcNext[MemBits-1:1];

   // Relative target counts from the branch's own PC
   assign redirectPc = branch.relMode ? pcQ + branch.target : branch.target;

   assign pc = fetchPc;

   assign fetchOut.valid = validQ;
   assign fetchOut.isLong = isLong;
   assign fetchOut.pc = pcQ;
   assign fetchOut.instruction = {secondHalf, firstHalf};

   always_ff @(posedge CLK or negedge arstN) begin
      if (!arstN) begin
         pcQ <= '0;
         validQ <= 1'b0;
      end else if (!run) begin
         // Restart from PC 0 once run rises
         pcQ <= '0;
         validQ <= 1'b0;
      end else if (branch.request) begin
         // Drop the wrong-path word already in flight
         pcQ <= redirectPc;
         validQ <= 1'b0;
      end else begin
         // Banks are lent out during a stall
         // so the next word is fetched again afterwards
         pcQ <= fetchPc;
         validQ <= !stall;
      end
   end

endmodule

/* logic/regFile.sv */
`timescale 1ns/1ps
`include "cpuCfg.svh"

// General registers, two reads and one write
module regFile (
   input  logic                               CLK,
   input  logic                               arstN,
   input  logic [$clog2(`CPU_REG_COUNT)-1:0]  rAddrA,
   input  logic [$clog2(`CPU_REG_COUNT)-1:0]  rAddrB,
   output logic [31:0]                        rDataA,
   output logic [31:0]                        rDataB,
   input  logic                               wEn,
   input  logic [$clog2(`CPU_REG_COUNT)-1:0]  wAddr,
   input  logic [31:0]                        wData
);

   // Register 0 has no storage
   logic [31:0] regs [1:`CPU_REG_COUNT-1];

   always_ff @(posedge CLK or negedge arstN) begin
      if (!arstN) begin
         for (int i = 1; i < `CPU_REG_COUNT; i++) begin
            regs[i] <= '0;
         end
      end else if (wEn && wAddr != '0) begin
         regs[wAddr] <= wData;
      end
   end

   assign rDataA = (rAddrA == '0) ? '0 : regs[rAddrA];
   assign rDataB = (rAddrB == '0) ? '0 : regs[rAddrB];

endmodule

/* logic/computeStage.sv */
`timescale 1ns/1ps
`include "cpuCfg.svh"

// Decode and execute
module computeStage (
   input  logic                                CLK,
   input  logic                                arstN,
   input  logic                                run,
   input  cpuPkg::fetchOut_t                   fetchIn,
   output cpuPkg::branchReq_t                  branch,
   output logic                                fetchStall,
   output cpuPkg::memReq_t                     memReq,
   input  logic [31:0]                         memRdata,
   output logic                                halted,
   output logic [`CPU_INSTR_HALFADDR_BITS-1:0] pc
);

   localparam int PcBits = `CPU_INSTR_HALFADDR_BITS;
   localparam int WordBits = `CPU_MEM_HALFADDR_BITS - 1;
   localparam int RegBits = $clog2(`CPU_REG_COUNT);

   typedef enum logic [1:0] {
      stExec,
      stLoadWait,
      stHalted
   } state_t;

   state_t state;
   // Destination of the load in flight
   logic [RegBits-1:0] loadRd;

   cpuPkg::opcode_t opcode;
   logic [RegBits-1:0] rd;
   logic [RegBits-1:0] rs;
   logic [15:0] imm16;
   logic [31:0] immSext;
   logic [31:0] rdVal;
   logic [31:0] rsVal;
   logic execute;
   logic isMem;
   logic [31:0] aluRes;
   logic aluWrite;
   logic [31:0] effAddr;
   logic regWen;
   logic [RegBits-1:0] regWaddr;
   logic [31:0] regWdata;

   // Instruction fields
   assign opcode = cpuPkg::opcode_t'(fetchIn.instruction[14:11]);
   assign rd = fetchIn.instruction[10:7];
   assign rs = fetchIn.instruction[6:3];
   assign imm16 = fetchIn.instruction[31:16];
   assign immSext = {{16{imm16[15]}}, imm16};

   // Only a fresh valid word in the exec state runs
   assign execute = run && state == stExec && fetchIn.valid;
   assign isMem = opcode == cpuPkg::OP_LD || opcode == cpuPkg::OP_ST;

   regFile u_regFile (
      .CLK    (CLK),
      .arstN  (arstN),
      .rAddrA (rd),
      .rAddrB (rs),
      .rDataA (rdVal),
      .rDataB (rsVal),
      .wEn    (regWen),
      .wAddr  (regWaddr),
      .wData  (regWdata)
   );

   // ALU, rd is both source and destination
   always_comb begin
      aluRes = '0;
      aluWrite = 1'b0;
      case (opcode)
         cpuPkg::OP_ADD: begin
            aluRes = rdVal + rsVal;
            aluWrite = 1'b1;
         end
         cpuPkg::OP_SUB: begin
            aluRes = rdVal - rsVal;
            aluWrite = 1'b1;
         end
         cpuPkg::OP_AND: begin
            aluRes = rdVal & rsVal;
            aluWrite = 1'b1;
         end
         cpuPkg::OP_OR: begin
            aluRes = rdVal | rsVal;
            aluWrite = 1'b1;
         end
         cpuPkg::OP_MOVI: begin
            aluRes = {28'd0, fetchIn.instruction[3:0]};
            aluWrite = 1'b1;
         end
         cpuPkg::OP_LI: begin
            aluRes = immSext;
            aluWrite = 1'b1;
         end
         cpuPkg::OP_ADDI: begin
            aluRes = rdVal + immSext;
            aluWrite = 1'b1;
         end
         default: begin
            aluRes = '0;
            aluWrite = 1'b0;
         end
      endcase
   end

   // Word index, wraps to the bank depth
   assign effAddr = rsVal + immSext;

   assign memReq.en = execute && isMem;
   assign memReq.wen = execute && opcode == cpuPkg::OP_ST;
   assign memReq.addr = effAddr[WordBits-1:0];
   assign memReq.wdata = rdVal;

   // One stall cycle for ST, two for LD
   assign fetchStall = (execute && isMem) || state == stLoadWait;

   // BEQ offset in halfwords, JMP absolute
   assign branch.request = execute &&
      ((opcode == cpuPkg::OP_BEQ && rdVal == rsVal) || opcode == cpuPkg::OP_JMP);
   assign branch.relMode = opcode == cpuPkg::OP_BEQ;
   assign branch.target = imm16[PcBits-1:0];

   // Load data arrives the cycle after the address
   always_comb begin
      if (run && state == stLoadWait) begin
         regWen = 1'b1;
         regWaddr = loadRd;
         regWdata = memRdata;
      end else begin
         regWen = execute && aluWrite;
         regWaddr = rd;
         regWdata = aluRes;
      end
   end

   always_ff @(posedge CLK) begin
      if (execute && opcode == cpuPkg::OP_LD) begin
         loadRd <= rd;
      end
   end

   always_ff @(posedge CLK or negedge arstN) begin
      if (!arstN) begin
         state <= stExec;
         pc <= '0;
      end else if (!run) begin
         state <= stExec;
         pc <= '0;
      end else begin
         case (state)
            stExec: begin
               if (fetchIn.valid) begin
                  // Architectural PC tracks the last executed word
                  pc <= fetchIn.pc;
                  if (opcode == cpuPkg::OP_LD) begin
                     state <= stLoadWait;
                  end else if (opcode == cpuPkg::OP_HALT) begin
                     state <= stHalted;
                  end
               end
            end
            stLoadWait: state <= stExec;
            // Stay halted until run drops
            default: state <= stHalted;
         endcase
      end
   end

   assign halted = state == stHalted;

endmodule

/* logic/cpuTop.sv */
`timescale 1ns/1ps
`include "cpuCfg.svh"

// Two-stage core with split halfword banks and loader port
module cpuTop (
   input  logic                              CLK,
   input  logic                              arstN,
   input  logic                              run,
   input  logic                              loadWen,
   input  logic [`CPU_MEM_HALFADDR_BITS-1:0] loadAddr,
   input  logic [15:0]                       loadWdata,
   output logic [15:0]                       loadRdata,
   output logic                              halted,
   output logic [31:0]                       PCout
);

   // Bank ports
   cpuPkg::bankPort_t lowPort;
   cpuPkg::bankPort_t highPort;
   logic [15:0] lowRdata;
   logic [15:0] highRdata;

   // Fetch side of the arbiter
   logic [`CPU_MEM_HALFADDR_BITS-2:0] fetchLowAddr;
   logic [`CPU_MEM_HALFADDR_BITS-2:0] fetchHighAddr;
   logic [15:0] fetchLowData;
   logic [15:0] fetchHighData;

   // Between the stages
   cpuPkg::fetchOut_t fetchOut;
   cpuPkg::branchReq_t branchReq;
   logic fetchStall;
   cpuPkg::memReq_t memReq;
   logic [31:0] memRdata;
   logic [`CPU_INSTR_HALFADDR_BITS-1:0] corePc;

   halfMemory u_lowMem (
      .CLK   (CLK),
      .port  (lowPort),
      .rdata (lowRdata)
   );

   halfMemory u_highMem (
      .CLK   (CLK),
      .port  (highPort),
      .rdata (highRdata)
   );

   memArbiter u_arbiter (
      .CLK           (CLK),
      .arstN         (arstN),
      .run           (run),
      .loadWen       (loadWen),
      .loadAddr      (loadAddr),
      .loadWdata     (loadWdata),
      .loadRdata     (loadRdata),
      .fetchLowAddr  (fetchLowAddr),
      .fetchHighAddr (fetchHighAddr),
      .fetchStall    (fetchStall),
      .memReq        (memReq),
      .memRdata      (memRdata),
      .fetchLowData  (fetchLowData),
      .fetchHighData (fetchHighData),
      .lowPort       (lowPort),
      .highPort      (highPort),
      .lowRdata      (lowRdata),
      .highRdata     (highRdata)
   );

   // Fetch address is debug only here, PCout follows the compute stage
   fetchStage u_fetch (
      .CLK      (CLK),
      .arstN    (arstN),
      .run      (run),
      .stall    (fetchStall),
      .branch   (branchReq),
      .lowAddr  (fetchLowAddr),
      .highAddr (fetchHighAddr),
      .lowData  (fetchLowData),
      .highData (fetchHighData),
      .fetchOut (fetchOut),
      .pc       ()
   );

   computeStage u_compute (
      .CLK        (CLK),
      .arstN      (arstN),
      .run        (run),
      .fetchIn    (fetchOut),
      .branch     (branchReq),
      .fetchStall (fetchStall),
      .memReq     (memReq),
      .memRdata   (memRdata),
      .halted     (halted),
      .pc         (corePc)
   );

   assign PCout = {{(32 - `CPU_INSTR_HALFADDR_BITS){1'b0}}, corePc};

endmodule

/* sim/cpuTb.sv */
`timescale 1ns/1ps
`include "cpuCfg.svh"

module cpuTb;

   localparam int AddrBits = `CPU_MEM_HALFADDR_BITS;
   // Cycles allowed for one program to reach HALT
   localparam int Timeout = 2000;

   logic CLK;
   logic arstN;
   logic run;
   logic loadWen;
   logic [AddrBits-1:0] loadAddr;
   logic [15:0] loadWdata;
   logic [15:0] loadRdata;
   logic halted;
   logic [31:0] PCout;

   // Records of the test being read
   logic [8*32-1:0] testName;
   logic [AddrBits-1:0] progAddr [$];
   logic [15:0] progData [$];
   logic [31:0] wordIdx [$];
   logic [31:0] wordData [$];
   logic [31:0] expPc;
   int testCount;

   cpuTop u_dut (
      .CLK       (CLK),
      .arstN     (arstN),
      .run       (run),
      .loadWen   (loadWen),
      .loadAddr  (loadAddr),
      .loadWdata (loadWdata),
      .loadRdata (loadRdata),
      .halted    (halted),
      .PCout     (PCout)
   );

   initial begin
      CLK = 1'b0;
      forever #5 CLK = ~CLK;
   end

   // Inputs change 1 ns after the rising edge
   task automatic stepCycle();
      @(posedge CLK);
      #1;
   endtask

   task automatic checkValue(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("CHECK FAILED %0s %0s: expected %h, actual %h",
                  testName, what, expected, actual);
         $display("test failed");
         $fatal(1, "Mismatch in %0s", testName);
      end
   endtask

   // Loader write, then an idle gap of 0 to 3 cycles
   task automatic writeHalf(input logic [AddrBits-1:0] addr, input logic [15:0] data);
      int gap;
      loadWen = 1'b1;
      loadAddr = addr;
      loadWdata = data;
      stepCycle();
      loadWen = 1'b0;
      gap = $urandom % 4;
      repeat (gap) stepCycle();
   endtask

   // Read data shows up one cycle after the address
   task automatic readHalf(input logic [AddrBits-1:0] addr, output logic [15:0] data);
      loadAddr = addr;
      stepCycle();
      data = loadRdata;
   endtask

   task automatic waitHalted(input int pass);
      int cycles;
      cycles = 0;
      while (!halted && cycles < Timeout) begin
         stepCycle();
         cycles++;
      end
      assert (halted) else begin
         $display("%0s run %0d: halted did not rise within %0d cycles",
                  testName, pass, Timeout);
         $display("test failed");
         $fatal(1, "Timeout waiting for halted");
      end
   endtask

   task automatic loadProgram();
      foreach (progAddr[i]) begin
         writeHalf(progAddr[i], progData[i]);
      end
   endtask

   // True when P records load the word directly
   function automatic logic wordLoaded(input logic [31:0] idx);
      foreach (progAddr[i]) begin
         if (progAddr[i] == AddrBits'(idx * 2)) begin
            return 1'b1;
         end
      end
      return 1'b0;
   endfunction

   // Words stored by the program get an address pattern
   // so only a fresh run from PC 0 brings them back
   task automatic clearStoredWords();
      logic [AddrBits-1:0] addr;
      foreach (wordIdx[i]) begin
         if (!wordLoaded(wordIdx[i])) begin
            addr = AddrBits'(wordIdx[i] * 2);
            writeHalf(addr, 16'(addr) ^ 16'hA5A5);
            writeHalf(addr + 1'b1, 16'(addr + 1'b1) ^ 16'hA5A5);
         end
      end
   endtask

   // One run from PC 0 up to HALT, then readback of the data words
   task automatic runProgram(input int pass);
      logic [15:0] lo;
      logic [15:0] hi;
      run = 1'b1;
      stepCycle();
      waitHalted(pass);
      checkValue($sformatf("run %0d final PC", pass), expPc, PCout);
      // halted and PC hold as long as run stays high
      repeat (3) begin
         stepCycle();
         checkValue($sformatf("run %0d halted held", pass), 32'd1, 32'(halted));
         checkValue($sformatf("run %0d PC held", pass), expPc, PCout);
      end
      run = 1'b0;
      stepCycle();
      checkValue($sformatf("run %0d halted cleared", pass), 32'd0, 32'(halted));
      checkValue($sformatf("run %0d PC cleared", pass), 32'd0, PCout);
      // Word i sits at halfwords 2i (low) and 2i+1 (high)
      foreach (wordIdx[i]) begin
         readHalf(AddrBits'(wordIdx[i] * 2), lo);
         readHalf(AddrBits'(wordIdx[i] * 2 + 1), hi);
         checkValue($sformatf("run %0d word %h", pass, wordIdx[i]), wordData[i], {hi, lo});
      end
   endtask

   initial begin
      int fd;
      int code;
      logic [8*32-1:0] tag;
      logic [8*256-1:0] line;
      logic [31:0] a;
      logic [31:0] v;
      void'($urandom(86494));
      arstN = 1'b0;
      run = 1'b0;
      loadWen = 1'b0;
      loadAddr = '0;
      loadWdata = '0;
      testCount = 0;
      testName = "reset";
      repeat (10) @(posedge CLK);
      #1;
      arstN = 1'b1;
      stepCycle();
      checkValue("halted after reset", 32'd0, 32'(halted));
      checkValue("PC after reset", 32'd0, PCout);

      fd = $fopen("sim/programInput.txt", "r");
      assert (fd != 0) else begin
         $display("Could not open sim/programInput.txt");
         $display("test failed");
         $fatal(1, "No input file");
      end

      while ($fscanf(fd, "%s", tag) == 1) begin
         case (tag)
            // Rest of a comment line is skipped
            "#": code = $fgets(line, fd);
            "T": code = $fscanf(fd, "%s", testName);
            "P": begin
               code = $fscanf(fd, "%h %h", a, v);
               progAddr.push_back(AddrBits'(a));
               progData.push_back(v[15:0]);
            end
            "M": begin
               code = $fscanf(fd, "%h %h", a, v);
               wordIdx.push_back(a);
               wordData.push_back(v);
            end
            "C": code = $fscanf(fd, "%h", expPc);
            "E": begin
               loadProgram();
               runProgram(1);
               // Second run must restart from PC 0 and store its words again
               clearStoredWords();
               runProgram(2);
               progAddr.delete();
               progData.delete();
               wordIdx.delete();
               wordData.delete();
               testCount++;
            end
            default: begin
               assert (1'b0) else begin
                  $display("Unknown record %0s in the input file", tag);
                  $display("test failed");
                  $fatal(1, "Bad input file");
               end
            end
         endcase
      end
      $fclose(fd);

      if (testCount > 0) begin
         $display("test passed");
         $finish;
      end else begin
         $display("The input file holds no complete test");
         $display("test failed");
         $fatal(1, "No tests");
      end
   end

endmodule

/* sim.f */
+incdir+logic
logic/cpuPkg.sv
logic/halfMemory.sv
logic/memArbiter.sv
logic/fetchStage.sv
logic/regFile.sv
logic/computeStage.sv
logic/cpuTop.sv
sim/cpuTb.sv

/* Makefile */
TOP := cpuTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build with Verilator and run the testbench"
	@echo "  make clean  remove the Verilator build directory"
	@echo "  make help   show this list"

# The run passes only when the pass line shows up in the simulator output
test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -x "test passed" > /dev/null

clean:
	rm -rf obj_dir

/* sim/programInput.txt */
# Records: T name | P halfword-address value | M word-index value | C final-pc | E
# Numbers in hex, P values are 16-bit halfwords and M values are 32-bit words
T aluOps
P 000 C080
P 001 7FFF
P 002 C100
P 003 8003
P 004 0090
P 005 D880
P 006 0100
P 007 218A
P 008 0990
P 009 C980
P 00A FFF0
P 00B D980
P 00C 0101
P 00D 220C
P 00E 1A08
P 00F 1218
P 010 DA00
P 011 0102
P 012 D900
P 013 0103
P 014 2800
M 100 00000002
M 101 00007FF7
M 102 00000006
M 103 FFFF8003
C 014
E
T loadStore
P 220 5678
P 221 1234
P 000 D280
P 001 0110
P 002 DA80
P 003 0111
P 004 C300
P 005 0112
P 006 D3B0
P 007 FFFF
P 008 CB80
P 009 0001
P 00A DBB0
P 00B 0000
P 00C 2800
M 110 12345678
M 111 12345678
M 112 12345679
C 00C
E
T branches
P 240 BEEF
P 241 DEAD
P 000 2085
P 001 2105
P 002 2186
P 003 E098
P 004 0010
P 005 E090
P 006 0006
P 007 D880
P 008 0120
P 009 E800
P 00A 000F
P 00B D980
P 00C 0121
P 00D E108
P 00E FFFC
P 00F D900
P 010 0122
P 011 2800
M 120 DEADBEEF
M 121 00000006
M 122 00000005
C 011
E
